//--- logic/radio_types_pkg.sv
// Vector types shared by the control plane
// Everything runs on dsp_clk, so no type carries clock-domain meaning

package radio_types_pkg;

   typedef logic [7:0]  set_addr_t;    // Settings register index
   typedef logic [31:0] set_data_t;    // Settings write and readback word
   typedef logic [63:0] vita_time_t;   // Free-running VITA tick count
   typedef logic [3:0]  rb_addr_t;     // Readback word index, 16 words
   typedef logic [7:0]  ctrl_byte_t;   // One misc control register
   typedef logic [11:0] axil_addr_t;   // Host byte address, 4 KB window

endpackage

//--- logic/settings_map_pkg.sv
// Settings register map and readback word map
// Only the misc and time64 ranges are decoded; every other index is ignored
// Readback words outside 10..15 return RB_UNUSED

package settings_map_pkg;

   import radio_types_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // Settings addresses

   // Misc block, offsets 0..6, offset 5 unused
   localparam set_addr_t  SR_MISC       = 8'd0;
   localparam ctrl_byte_t LED_SRC_RESET = 8'h1E;   // Bits 4:1 on hardware

   // Time block: +0 ticks high, +1 ticks low and commit, +2 imm
   localparam set_addr_t  SR_TIME64     = 8'd10;

   //////////////////////////////////////////////////////////////////////
   // Readback words

   localparam rb_addr_t   RB_TIME_HI    = 4'd10;
   localparam rb_addr_t   RB_TIME_LO    = 4'd11;
   localparam rb_addr_t   RB_COMPAT     = 4'd12;
   localparam rb_addr_t   RB_STATUS     = 4'd13;
   localparam rb_addr_t   RB_PPS_HI     = 4'd14;
   localparam rb_addr_t   RB_PPS_LO     = 4'd15;

   localparam set_data_t  RB_UNUSED     = 32'hFFFF_FFFF;

   // Bump the major part when the register map changes
   localparam set_data_t  COMPAT_NUM    = {16'd10, 16'd0};   // Major, minor

   // Status word layout, other bits read 0
   localparam int STATUS_BUTTON_BIT = 13;
   localparam int STATUS_CLK_BIT    = 11;
   localparam int STATUS_LINK_BIT   = 10;

endpackage

//--- logic/settings_if.sv
// Settings write strobe and readback lookup between the host slave and
// the register blocks. A write is a single-cycle set_stb
// rb_data must be a combinational function of rb_addr

`timescale 1ns/10ps

interface settings_if;

   import radio_types_pkg::*;

   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;
   rb_addr_t  rb_addr;
   set_data_t rb_data;

   modport master (output set_stb, set_addr, set_data, rb_addr,
                   input  rb_data);

   // Sinks decode set_addr themselves
   modport sink (input set_stb, set_addr, set_data);

   modport readback (input rb_addr, output rb_data);

endinterface

//--- logic/axil_settings_slave.sv
// AXI4-Lite slave in front of the settings bus
// One write and one read in flight at most; nothing is pipelined
// Full-word writes only, the write strobes are ignored
// Responses are always OKAY

`timescale 1ns/10ps

module axil_settings_slave (
   input  logic                        dsp_clk,
   input  logic                        por_rst,

   input  radio_types_pkg::axil_addr_t s_axil_awaddr_i,
   input  logic                        s_axil_awvalid_i,
   output logic                        s_axil_awready_o,
   input  radio_types_pkg::set_data_t  s_axil_wdata_i,
   input  logic                        s_axil_wvalid_i,
   output logic                        s_axil_wready_o,
   output logic                        s_axil_bvalid_o,
   input  logic                        s_axil_bready_i,
   output logic [1:0]                  s_axil_bresp_o,

   input  radio_types_pkg::axil_addr_t s_axil_araddr_i,
   input  logic                        s_axil_arvalid_i,
   output logic                        s_axil_arready_o,
   output radio_types_pkg::set_data_t  s_axil_rdata_o,
   output logic [1:0]                  s_axil_rresp_o,
   output logic                        s_axil_rvalid_o,
   input  logic                        s_axil_rready_i,

   settings_if.master                  set_bus
);

   logic wr_accept;
   logic rd_accept;

   // Address and data taken together, held off while a response is pending
   assign wr_accept = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_bvalid_o;
   assign rd_accept = s_axil_arvalid_i && !s_axil_rvalid_o;

   assign s_axil_awready_o = wr_accept;
   assign s_axil_wready_o  = wr_accept;
   assign s_axil_arready_o = rd_accept;

   assign s_axil_bresp_o = 2'b00;   // OKAY
   assign s_axil_rresp_o = 2'b00;

   assign set_bus.rb_addr = s_axil_araddr_i[5:2];   // Word index

   //////////////////////////////////////////////////////////////////////
   // Write path

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         set_bus.set_stb <= 1'b0;
         s_axil_bvalid_o <= 1'b0;
      end else begin
         set_bus.set_stb <= wr_accept;   // One pulse per accepted write
         if (wr_accept)
            s_axil_bvalid_o <= 1'b1;
         else if (s_axil_bready_i)
            s_axil_bvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (wr_accept) begin
         set_bus.set_addr <= s_axil_awaddr_i[9:2];
         set_bus.set_data <= s_axil_wdata_i;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read path

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         s_axil_rvalid_o <= 1'b0;
      end else if (rd_accept) begin
         s_axil_rvalid_o <= 1'b1;
      end else if (s_axil_rready_i) begin
         s_axil_rvalid_o <= 1'b0;
      end
   end

   // Readback word captured at acceptance
   always_ff @(posedge dsp_clk) begin
      if (rd_accept)
         s_axil_rdata_o <= set_bus.rb_data;
   end

   // Sinks see each write exactly once
   a_single_strobe : assert property (@(posedge dsp_clk) disable iff (por_rst)
      set_bus.set_stb |=> !set_bus.set_stb);

endmodule

//--- logic/misc_ctrl.sv
// Misc control registers and the LED source mux
// A led_src bit of 1 gives that LED to hardware status, 0 to led_sw
// phy_resetn_o is high out of reset

`timescale 1ns/10ps

module misc_ctrl (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   settings_if.sink                    set_bus,

   input  logic                        run_tx_i,
   input  logic                        run_rx_i,
   input  logic                        clk_status_i,
   input  logic                        serdes_link_up_i,
   input  logic                        good_sync_i,

   output radio_types_pkg::ctrl_byte_t leds_o,
   output logic                        clock_ready_o,
   output logic [1:0]                  clk_en_o,
   output logic [1:0]                  clk_sel_o,
   output logic                        ser_enable_o,
   output logic                        ser_prbsen_o,
   output logic                        ser_loopen_o,
   output logic                        ser_rx_en_o,
   output logic                        adc_oe_a_o,
   output logic                        adc_on_a_o,
   output logic                        adc_oe_b_o,
   output logic                        adc_on_b_o,
   output logic                        phy_resetn_o
);

   import radio_types_pkg::*;
   import settings_map_pkg::*;

   logic [4:0] clock_r;    // Only the bits that reach pins are kept
   logic [3:0] serdes_r;
   logic [3:0] adc_r;
   ctrl_byte_t led_sw_r;
   ctrl_byte_t led_src_r;
   logic       phy_reset_r;
   ctrl_byte_t led_hw;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         clock_r     <= '0;
         serdes_r    <= '0;
         adc_r       <= '0;
         led_sw_r    <= '0;
         led_src_r   <= LED_SRC_RESET;
         phy_reset_r <= 1'b0;
      end else if (set_bus.set_stb) begin
         case (set_bus.set_addr)
            SR_MISC + 8'd0: clock_r     <= set_bus.set_data[4:0];
            SR_MISC + 8'd1: serdes_r    <= set_bus.set_data[3:0];
            SR_MISC + 8'd2: adc_r       <= set_bus.set_data[3:0];
            SR_MISC + 8'd3: led_sw_r    <= set_bus.set_data[7:0];
            SR_MISC + 8'd4: phy_reset_r <= set_bus.set_data[0];
            SR_MISC + 8'd6: led_src_r   <= set_bus.set_data[7:0];
            default: ;
         endcase
      end
   end

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_r;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_r;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_r;
   assign phy_resetn_o = !phy_reset_r;

   // Link LED only lit once the time base has locked to PPS
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i,
                    serdes_link_up_i && good_sync_i, 1'b0};

   assign leds_o = (led_src_r & led_hw) | (~led_src_r & led_sw_r);

endmodule

//--- logic/time_regs.sv
// Time-set registers: ticks high, ticks low and the imm flag
// Writing ticks low commits the set, so write high first
// imm must be written before the commit it applies to

`timescale 1ns/10ps

module time_regs (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   settings_if.sink                    set_bus,
   output radio_types_pkg::vita_time_t new_time_o,
   output logic                        set_now_o,
   output logic                        set_at_pps_o
);

   import radio_types_pkg::*;
   import settings_map_pkg::*;

   set_data_t ticks_hi_r;
   set_data_t ticks_lo_r;
   logic      imm_r;
   logic      commit;

   assign commit = set_bus.set_stb && (set_bus.set_addr == SR_TIME64 + 8'd1);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         imm_r        <= 1'b0;
         set_now_o    <= 1'b0;
         set_at_pps_o <= 1'b0;
      end else begin
         set_now_o    <= commit && imm_r;
         set_at_pps_o <= commit && !imm_r;   // Wait for next PPS edge
         if (set_bus.set_stb && (set_bus.set_addr == SR_TIME64 + 8'd2))
            imm_r <= set_bus.set_data[0];
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (set_bus.set_stb && (set_bus.set_addr == SR_TIME64))
         ticks_hi_r <= set_bus.set_data;
      if (commit)
         ticks_lo_r <= set_bus.set_data;
   end

   assign new_time_o = {ticks_hi_r, ticks_lo_r};

endmodule

//--- logic/vita_time_core.sv
// 64-bit VITA time base with PPS capture
// pps_i is asynchronous; a rising edge takes effect three cycles after
// it is first sampled. good_sync stays set until reset

`timescale 1ns/10ps

module vita_time_core (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  logic                        pps_i,
   input  radio_types_pkg::vita_time_t new_time_i,
   input  logic                        set_now_i,
   input  logic                        set_at_pps_i,
   output radio_types_pkg::vita_time_t vita_time_o,
   output radio_types_pkg::vita_time_t vita_time_pps_o,
   output logic                        good_sync_o
);

   import radio_types_pkg::*;

   logic [1:0] pps_sync;      // Two-flop synchroniser
   logic       pps_last;
   logic       pps_edge;      // Registered rising edge
   logic       set_pending;
   vita_time_t time_next;

   // Value the counter holds after the coming edge
   always_comb begin
      if (set_now_i || (pps_edge && set_pending))
         time_next = new_time_i;
      else
         time_next = vita_time_o + 64'd1;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_sync    <= '0;
         pps_last    <= 1'b0;
         pps_edge    <= 1'b0;
         set_pending <= 1'b0;
         good_sync_o <= 1'b0;
         vita_time_o <= '0;
      end else begin
         pps_sync    <= {pps_sync[0], pps_i};
         pps_last    <= pps_sync[1];
         pps_edge    <= pps_sync[1] && !pps_last;
         vita_time_o <= time_next;
         if (set_at_pps_i)
            set_pending <= 1'b1;        // Newer request replaces older
         else if (set_now_i || pps_edge)
            set_pending <= 1'b0;
         if (pps_edge)
            good_sync_o <= 1'b1;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (pps_edge)
         vita_time_pps_o <= time_next;
   end

   // Pending-flag priority assumes one kind of set request per commit
   a_one_set_kind : assert property (@(posedge dsp_clk) disable iff (por_rst)
      !(set_now_i && set_at_pps_i));

endmodule

//--- logic/readback_mux.sv
// Readback word selection, purely combinational
// Words 10..15 are mapped, all others read RB_UNUSED

`timescale 1ns/10ps

module readback_mux (
   settings_if.readback                rb_bus,
   input  radio_types_pkg::vita_time_t vita_time_i,
   input  radio_types_pkg::vita_time_t vita_time_pps_i,
   input  logic                        button_i,
   input  logic                        clk_status_i,
   input  logic                        serdes_link_up_i
);

   import radio_types_pkg::*;
   import settings_map_pkg::*;

   set_data_t status_word;

   always_comb begin
      status_word = '0;
      status_word[STATUS_BUTTON_BIT] = button_i;
      status_word[STATUS_CLK_BIT]    = clk_status_i;
      status_word[STATUS_LINK_BIT]   = serdes_link_up_i;
   end

   always_comb begin
      case (rb_bus.rb_addr)
         RB_TIME_HI: rb_bus.rb_data = vita_time_i[63:32];
         RB_TIME_LO: rb_bus.rb_data = vita_time_i[31:0];
         RB_COMPAT:  rb_bus.rb_data = COMPAT_NUM;
         RB_STATUS:  rb_bus.rb_data = status_word;
         RB_PPS_HI:  rb_bus.rb_data = vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_bus.rb_data = vita_time_pps_i[31:0];
         default:    rb_bus.rb_data = RB_UNUSED;
      endcase
   end

endmodule

//--- logic/radio_ctrl_top.sv
// Radio control plane top: host AXI4-Lite slave, misc controls, LEDs,
// VITA time base and readback. Single clock, synchronous active-high reset
// Datapath run and link states come in as plain status inputs

`timescale 1ns/10ps

module radio_ctrl_top (
   input  logic                        dsp_clk,
   input  logic                        por_rst,

   input  radio_types_pkg::axil_addr_t s_axil_awaddr_i,
   input  logic                        s_axil_awvalid_i,
   output logic                        s_axil_awready_o,
   input  radio_types_pkg::set_data_t  s_axil_wdata_i,
   input  logic                        s_axil_wvalid_i,
   output logic                        s_axil_wready_o,
   output logic                        s_axil_bvalid_o,
   input  logic                        s_axil_bready_i,
   output logic [1:0]                  s_axil_bresp_o,
   input  radio_types_pkg::axil_addr_t s_axil_araddr_i,
   input  logic                        s_axil_arvalid_i,
   output logic                        s_axil_arready_o,
   output radio_types_pkg::set_data_t  s_axil_rdata_o,
   output logic [1:0]                  s_axil_rresp_o,
   output logic                        s_axil_rvalid_o,
   input  logic                        s_axil_rready_i,

   input  logic                        pps_i,
   input  logic                        run_tx_i,
   input  logic                        run_rx_i,
   input  logic                        clk_status_i,
   input  logic                        serdes_link_up_i,
   input  logic                        button_i,

   output radio_types_pkg::ctrl_byte_t leds_o,
   output logic                        clock_ready_o,
   output logic [1:0]                  clk_en_o,
   output logic [1:0]                  clk_sel_o,
   output logic                        ser_enable_o,
   output logic                        ser_prbsen_o,
   output logic                        ser_loopen_o,
   output logic                        ser_rx_en_o,
   output logic                        adc_oe_a_o,
   output logic                        adc_on_a_o,
   output logic                        adc_oe_b_o,
   output logic                        adc_on_b_o,
   output logic                        phy_resetn_o
);

   import radio_types_pkg::*;

   vita_time_t vita_time;
   vita_time_t vita_time_pps;
   vita_time_t new_time;
   logic       set_now;
   logic       set_at_pps;
   logic       good_sync;

   settings_if set_bus ();

   //////////////////////////////////////////////////////////////////////
   // Host access

   axil_settings_slave u_axil (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .s_axil_awaddr_i  (s_axil_awaddr_i),
      .s_axil_awvalid_i (s_axil_awvalid_i),
      .s_axil_awready_o (s_axil_awready_o),
      .s_axil_wdata_i   (s_axil_wdata_i),
      .s_axil_wvalid_i  (s_axil_wvalid_i),
      .s_axil_wready_o  (s_axil_wready_o),
      .s_axil_bvalid_o  (s_axil_bvalid_o),
      .s_axil_bready_i  (s_axil_bready_i),
      .s_axil_bresp_o   (s_axil_bresp_o),
      .s_axil_araddr_i  (s_axil_araddr_i),
      .s_axil_arvalid_i (s_axil_arvalid_i),
      .s_axil_arready_o (s_axil_arready_o),
      .s_axil_rdata_o   (s_axil_rdata_o),
      .s_axil_rresp_o   (s_axil_rresp_o),
      .s_axil_rvalid_o  (s_axil_rvalid_o),
      .s_axil_rready_i  (s_axil_rready_i),
      .set_bus          (set_bus)
   );

   //////////////////////////////////////////////////////////////////////
   // Register blocks

   misc_ctrl u_misc (
      .dsp_clk          (dsp_clk),
      .por_rst          (por_rst),
      .set_bus          (set_bus),
      .run_tx_i         (run_tx_i),
      .run_rx_i         (run_rx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .good_sync_i      (good_sync),
      .leds_o           (leds_o),
      .clock_ready_o    (clock_ready_o),
      .clk_en_o         (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),
      .ser_prbsen_o     (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),
      .ser_rx_en_o      (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),
      .adc_on_a_o       (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),
      .adc_on_b_o       (adc_on_b_o),
      .phy_resetn_o     (phy_resetn_o)
   );

   time_regs u_time_regs (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .set_bus      (set_bus),
      .new_time_o   (new_time),
      .set_now_o    (set_now),
      .set_at_pps_o (set_at_pps)
   );

   vita_time_core u_vita_time (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .pps_i           (pps_i),
      .new_time_i      (new_time),
      .set_now_i       (set_now),
      .set_at_pps_i    (set_at_pps),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps),
      .good_sync_o     (good_sync)
   );

   readback_mux u_readback (
      .rb_bus           (set_bus),
      .vita_time_i      (vita_time),
      .vita_time_pps_i  (vita_time_pps),
      .button_i         (button_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i)
   );

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and power-on reset
// 40 ns period, reset released 2 ns after the fifth rising edge

`timescale 1ns/10ps

module tb_clk_gen (
   output logic dsp_clk,
   output logic por_rst
);

   localparam int HALF_PERIOD = 20;

   initial begin
      dsp_clk = 1'b0;
      forever #HALF_PERIOD dsp_clk = ~dsp_clk;
   end

   initial begin
      por_rst = 1'b1;
      repeat (5) @(posedge dsp_clk);
      #2;   // Off the edge, like every other input
      por_rst = 1'b0;
   end

endmodule

//--- verif/radio_ctrl_tb.sv
// Directed testbench for the radio control plane, host access over AXI4-Lite
// Inputs change 2 ns after the rising edge and outputs are sampled there too
// Ready outputs are combinational and are sampled at the falling edge
// Stops at the first mismatch

`timescale 1ns/10ps

module radio_ctrl_tb;

   import radio_types_pkg::*;
   import settings_map_pkg::*;

   localparam int NUM_TESTS       = 6;
   localparam int CYCLES_PER_TEST = 200;
   localparam int HANDSHAKE_LIMIT = 50;   // Cycles before a response counts as lost

   logic       dsp_clk;
   logic       por_rst;
   axil_addr_t s_axil_awaddr_i;
   logic       s_axil_awvalid_i;
   logic       s_axil_awready_o;
   set_data_t  s_axil_wdata_i;
   logic       s_axil_wvalid_i;
   logic       s_axil_wready_o;
   logic       s_axil_bvalid_o;
   logic       s_axil_bready_i;
   logic [1:0] s_axil_bresp_o;
   axil_addr_t s_axil_araddr_i;
   logic       s_axil_arvalid_i;
   logic       s_axil_arready_o;
   set_data_t  s_axil_rdata_o;
   logic [1:0] s_axil_rresp_o;
   logic       s_axil_rvalid_o;
   logic       s_axil_rready_i;
   logic       pps_i;
   logic       run_tx_i;
   logic       run_rx_i;
   logic       clk_status_i;
   logic       serdes_link_up_i;
   logic       button_i;
   ctrl_byte_t leds_o;
   logic       clock_ready_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic       ser_enable_o;
   logic       ser_prbsen_o;
   logic       ser_loopen_o;
   logic       ser_rx_en_o;
   logic       adc_oe_a_o;
   logic       adc_on_a_o;
   logic       adc_oe_b_o;
   logic       adc_on_b_o;
   logic       phy_resetn_o;
   logic       sync_seen;   // Set once a PPS edge has reached the DUT

   tb_clk_gen u_clk_gen (.dsp_clk(dsp_clk), .por_rst(por_rst));

   radio_ctrl_top dut (.*);

   //////////////////////////////////////////////////////////////////////
   // Reporting and compare tasks

   task automatic stop_on_error(input string reason);
      $display("%s", reason);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_data(input string name, input set_data_t got, input set_data_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_byte(input string name, input ctrl_byte_t got, input ctrl_byte_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   task automatic check_time(input string name, input vita_time_t got, input vita_time_t exp);
      if (got !== exp)
         stop_on_error($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
   endtask

   // Each LED takes hardware status where led_src is 1, led_sw where it is 0
   function automatic ctrl_byte_t led_model(input ctrl_byte_t sw, input ctrl_byte_t src);
      ctrl_byte_t hw;
      ctrl_byte_t leds;
      hw    = '0;
      hw[4] = run_tx_i;
      hw[3] = run_rx_i;
      hw[2] = clk_status_i;
      hw[1] = serdes_link_up_i && sync_seen;
      for (int b = 0; b < 8; b++)
         leds[b] = src[b] ? hw[b] : sw[b];
      return leds;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Bus tasks, called and returning 2 ns after an edge

   task automatic step_cycles(input int n);
      repeat (n) @(posedge dsp_clk);
      #2;
   endtask

   task automatic axil_write(input set_addr_t idx, input set_data_t data);
      int waited;
      waited           = 0;
      s_axil_awaddr_i  = {2'b00, idx, 2'b00};
      s_axil_wdata_i   = data;
      s_axil_awvalid_i = 1'b1;
      s_axil_wvalid_i  = 1'b1;
      @(negedge dsp_clk);
      while (!(s_axil_awready_o && s_axil_wready_o)) begin
         waited++;
         if (waited > HANDSHAKE_LIMIT)
            stop_on_error($sformatf("Write to settings index %0d was never accepted", idx));
         @(negedge dsp_clk);
      end
      step_cycles(1);   // Accepting edge
      check_byte("s_axil_bvalid_o", ctrl_byte_t'(s_axil_bvalid_o), 8'h01);
      check_byte("s_axil_bresp_o", ctrl_byte_t'(s_axil_bresp_o), 8'h00);
      // No second write while the response is pending
      check_byte("s_axil_awready_o", ctrl_byte_t'(s_axil_awready_o), 8'h00);
      s_axil_awvalid_i = 1'b0;
      s_axil_wvalid_i  = 1'b0;
      s_axil_bready_i  = 1'b1;
      step_cycles(1);
      s_axil_bready_i  = 1'b0;
      step_cycles(2);
   endtask

   task automatic axil_read(input rb_addr_t idx, output set_data_t data);
      int waited;
      waited           = 0;
      s_axil_araddr_i  = {6'd0, idx, 2'b00};
      s_axil_arvalid_i = 1'b1;
      @(negedge dsp_clk);
      while (!s_axil_arready_o) begin
         waited++;
         if (waited > HANDSHAKE_LIMIT)
            stop_on_error($sformatf("Read of readback word %0d was never accepted", idx));
         @(negedge dsp_clk);
      end
      step_cycles(1);   // Accepting edge
      check_byte("s_axil_rvalid_o", ctrl_byte_t'(s_axil_rvalid_o), 8'h01);
      data = s_axil_rdata_o;
      check_byte("s_axil_rresp_o", ctrl_byte_t'(s_axil_rresp_o), 8'h00);
      check_byte("s_axil_arready_o", ctrl_byte_t'(s_axil_arready_o), 8'h00);
      s_axil_arvalid_i = 1'b0;
      s_axil_rready_i  = 1'b1;
      step_cycles(1);
      s_axil_rready_i  = 1'b0;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic test_reset_state();
      check_byte("clock pins", ctrl_byte_t'({clock_ready_o, clk_en_o, clk_sel_o}), 8'h00);
      check_byte("serdes pins",
                 ctrl_byte_t'({ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o}), 8'h00);
      check_byte("adc pins",
                 ctrl_byte_t'({adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o}), 8'h00);
      check_byte("phy_resetn_o", ctrl_byte_t'(phy_resetn_o), 8'h01);
      check_byte("leds_o", leds_o, 8'h00);
      run_tx_i     = 1'b1;
      clk_status_i = 1'b1;
      step_cycles(1);
      check_byte("leds_o", leds_o, 8'h14);   // Default source puts these on hardware
      run_tx_i     = 1'b0;
      clk_status_i = 1'b0;
   endtask

   task automatic test_misc_regs();
      ctrl_byte_t clk_v;
      ctrl_byte_t ser_v;
      ctrl_byte_t adc_v;
      clk_v = ctrl_byte_t'($urandom);
      ser_v = ctrl_byte_t'($urandom);
      adc_v = ctrl_byte_t'($urandom);
      axil_write(SR_MISC + 8'd0, set_data_t'(clk_v));
      axil_write(SR_MISC + 8'd1, set_data_t'(ser_v));
      axil_write(SR_MISC + 8'd2, set_data_t'(adc_v));
      axil_write(SR_MISC + 8'd4, 32'd1);
      check_byte("clock_ready_o", ctrl_byte_t'(clock_ready_o), ctrl_byte_t'(clk_v[4]));
      check_byte("clk_en_o", ctrl_byte_t'(clk_en_o), ctrl_byte_t'(clk_v[3:2]));
      check_byte("clk_sel_o", ctrl_byte_t'(clk_sel_o), ctrl_byte_t'(clk_v[1:0]));
      check_byte("ser_enable_o", ctrl_byte_t'(ser_enable_o), ctrl_byte_t'(ser_v[3]));
      check_byte("ser_prbsen_o", ctrl_byte_t'(ser_prbsen_o), ctrl_byte_t'(ser_v[2]));
      check_byte("ser_loopen_o", ctrl_byte_t'(ser_loopen_o), ctrl_byte_t'(ser_v[1]));
      check_byte("ser_rx_en_o", ctrl_byte_t'(ser_rx_en_o), ctrl_byte_t'(ser_v[0]));
      check_byte("adc_oe_a_o", ctrl_byte_t'(adc_oe_a_o), ctrl_byte_t'(adc_v[3]));
      check_byte("adc_on_a_o", ctrl_byte_t'(adc_on_a_o), ctrl_byte_t'(adc_v[2]));
      check_byte("adc_oe_b_o", ctrl_byte_t'(adc_oe_b_o), ctrl_byte_t'(adc_v[1]));
      check_byte("adc_on_b_o", ctrl_byte_t'(adc_on_b_o), ctrl_byte_t'(adc_v[0]));
      check_byte("phy_resetn_o", ctrl_byte_t'(phy_resetn_o), 8'h00);
   endtask

   task automatic test_led_mux();
      ctrl_byte_t sw;
      ctrl_byte_t src;
      ctrl_byte_t stat;
      for (int i = 0; i < 4; i++) begin
         sw   = ctrl_byte_t'($urandom);
         src  = ctrl_byte_t'($urandom);
         stat = ctrl_byte_t'($urandom);
         axil_write(SR_MISC + 8'd3, set_data_t'(sw));
         axil_write(SR_MISC + 8'd6, set_data_t'(src));
         run_tx_i         = stat[0];
         run_rx_i         = stat[1];
         clk_status_i     = stat[2];
         serdes_link_up_i = stat[3];
         step_cycles(1);
         check_byte("leds_o", leds_o, led_model(sw, src));
      end
   endtask

   task automatic test_readback_map();
      set_data_t  got;
      set_data_t  exp;
      ctrl_byte_t stat;
      axil_read(RB_COMPAT, got);
      check_data("compat word", got, 32'h000A_0000);
      for (int i = 0; i < 3; i++) begin
         stat             = ctrl_byte_t'($urandom);
         button_i         = stat[0];
         clk_status_i     = stat[1];
         serdes_link_up_i = stat[2];
         step_cycles(1);
         exp     = '0;
         exp[13] = stat[0];   // Button
         exp[11] = stat[1];
         exp[10] = stat[2];   // Link
         axil_read(RB_STATUS, got);
         check_data("status word", got, exp);
      end
      axil_read(4'd0, got);
      check_data("readback word 0", got, 32'hFFFF_FFFF);
      axil_read(4'd9, got);
      check_data("readback word 9", got, 32'hFFFF_FFFF);
   endtask

   task automatic test_time_immediate();
      set_data_t hi;
      set_data_t lo;
      set_data_t got;
      hi = $urandom;
      lo = $urandom & 32'h7FFF_FFFF;   // Keeps the low word clear of wrapping
      axil_write(SR_TIME64 + 8'd2, 32'd1);
      axil_write(SR_TIME64 + 8'd0, hi);
      axil_write(SR_TIME64 + 8'd1, lo);
      axil_read(RB_TIME_HI, got);
      check_data("time high", got, hi);
      axil_read(RB_TIME_LO, got);
      if (got < lo || got > lo + 32'd20)
         stop_on_error($sformatf("FAIL time low: got 0x%h, expected 0x%h to 0x%h",
                                 got, lo, lo + 32'd20));
   endtask

   task automatic test_time_at_pps();
      vita_time_t new_time;
      set_data_t  pps_hi;
      set_data_t  pps_lo;
      ctrl_byte_t sw;
      ctrl_byte_t src;
      new_time = {$urandom, $urandom};
      axil_write(SR_TIME64 + 8'd2, 32'd0);
      axil_write(SR_TIME64 + 8'd0, new_time[63:32]);
      axil_write(SR_TIME64 + 8'd1, new_time[31:0]);
      pps_i = 1'b1;
      step_cycles(6);   // Edge acts three cycles after it is sampled
      pps_i = 1'b0;
      sync_seen = 1'b1;
      step_cycles(2);
      axil_read(RB_PPS_HI, pps_hi);
      axil_read(RB_PPS_LO, pps_lo);
      check_time("pps time", {pps_hi, pps_lo}, new_time);

      // Link LED needs both the link and a completed sync
      sw               = ctrl_byte_t'($urandom);
      src              = ctrl_byte_t'($urandom) | 8'h02;
      serdes_link_up_i = 1'b1;
      axil_write(SR_MISC + 8'd3, set_data_t'(sw));
      axil_write(SR_MISC + 8'd6, set_data_t'(src));
      check_byte("leds_o[1]", ctrl_byte_t'(leds_o[1]), 8'h01);
      check_byte("leds_o", leds_o, led_model(sw, src));
   endtask

   //////////////////////////////////////////////////////////////////////
   // Run control

   initial begin
      repeat (NUM_TESTS * CYCLES_PER_TEST + 100) @(posedge dsp_clk);
      stop_on_error("Watchdog expired before all tests finished");
   end

   initial begin
      s_axil_awaddr_i  = '0;
      s_axil_awvalid_i = 1'b0;
      s_axil_wdata_i   = '0;
      s_axil_wvalid_i  = 1'b0;
      s_axil_bready_i  = 1'b0;
      s_axil_araddr_i  = '0;
      s_axil_arvalid_i = 1'b0;
      s_axil_rready_i  = 1'b0;
      pps_i            = 1'b0;
      run_tx_i         = 1'b0;
      run_rx_i         = 1'b0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      button_i         = 1'b0;
      sync_seen        = 1'b0;
      void'($urandom(16));
      @(negedge por_rst);
      step_cycles(1);
      test_reset_state();
      test_misc_regs();
      test_led_mux();
      test_readback_map();
      test_time_immediate();
      test_time_at_pps();
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- radio_ctrl.f
logic/radio_types_pkg.sv
logic/settings_map_pkg.sv
logic/settings_if.sv
logic/axil_settings_slave.sv
logic/misc_ctrl.sv
logic/time_regs.sv
logic/vita_time_core.sv
logic/readback_mux.sv
logic/radio_ctrl_top.sv
verif/tb_clk_gen.sv
verif/radio_ctrl_tb.sv

//--- Makefile
# Verilator flow for the radio control plane

TOP := radio_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f radio_ctrl.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert -f radio_ctrl.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
